/* bpu/bpu.sv */
`timescale 1ns/1ns
`default_nettype none

module bpu #(
    parameter int INDEX_WIDTH = 6,
    parameter int TAG_WIDTH   = 8
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    stall,
    input  wire bpu_types_pkg::addr_t    fetch_pc,
    output logic                         predict_valid,
    output bpu_types_pkg::predict_t      predict,
    input  wire logic                    inval_valid,
    input  wire bpu_types_pkg::addr_t    inval_pc,
    resolve_if.bpu_side                  upd
);

    logic [INDEX_WIDTH-1:0]       history;
    logic [INDEX_WIDTH-1:0]       lookup_index;
    logic [INDEX_WIDTH-1:0]       upd_index;
    bpu_types_pkg::counter_e      lookup_counter;
    bpu_types_pkg::counter_e      lookup_counter_q;
    bpu_types_pkg::counter_e      upd_counter;
    bpu_types_pkg::counter_e      upd_counter_q;
    bpu_types_pkg::counter_e      upd_counter_next;
    bpu_types_pkg::update_state_e state;
    bpu_types_pkg::resolved_t     upd_entry;
    logic                         pht_write;
    logic                         btb_alloc;
    logic                         btb_hit;
    logic                         lookup_taken;
    bpu_types_pkg::addr_t         btb_target;

    assign lookup_index = fetch_pc[INDEX_WIDTH+1:2] ^ history;
    assign upd_index    = upd_entry.pc[INDEX_WIDTH+1:2] ^ history; // history is stable until the write edge.

    assign pht_write = (state == bpu_types_pkg::upd_write);
    assign btb_alloc = pht_write && upd_entry.taken;
    assign upd.credit = pht_write;

    pattern_history_table #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_pht (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .lookup_state (lookup_counter),
        .update_index (upd_index),
        .update_state (upd_counter),
        .write_en     (pht_write),
        .write_state  (upd_counter_next)
    );

    branch_target_buffer #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .TAG_WIDTH   (TAG_WIDTH)
    ) u_btb (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .lookup_pc    (fetch_pc),
        .hit          (btb_hit),
        .target       (btb_target),
        .alloc_en     (btb_alloc),
        .alloc_pc     (upd_entry.pc),
        .alloc_target (upd_entry.target),
        .inval_en     (inval_valid),
        .inval_pc     (inval_pc)
    );

    // counter read lines up with the registered btb result.
    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_counter_q <= bpu_types_pkg::weak_not_taken;
        end else if (!stall) begin
            lookup_counter_q <= lookup_counter;
        end
    end

    assign lookup_taken = (lookup_counter_q == bpu_types_pkg::weak_taken) ||
                          (lookup_counter_q == bpu_types_pkg::strong_taken);
    assign predict_valid = btb_hit && lookup_taken;
    assign predict.npc   = btb_target;

    // saturating step; strong_not_taken and strong_taken are the two ends.
    always_comb begin
        upd_counter_next = upd_counter_q;
        if (upd_entry.taken) begin
            case (upd_counter_q)
                bpu_types_pkg::strong_not_taken: upd_counter_next = bpu_types_pkg::weak_not_taken;
                bpu_types_pkg::weak_not_taken:   upd_counter_next = bpu_types_pkg::weak_taken;
                default:                         upd_counter_next = bpu_types_pkg::strong_taken;
            endcase
        end else begin
            case (upd_counter_q)
                bpu_types_pkg::strong_taken:   upd_counter_next = bpu_types_pkg::weak_taken;
                bpu_types_pkg::weak_taken:     upd_counter_next = bpu_types_pkg::weak_not_taken;
                default:                       upd_counter_next = bpu_types_pkg::strong_not_taken;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= bpu_types_pkg::upd_idle;
            history <= '0;
        end else begin
            case (state)
                bpu_types_pkg::upd_idle: begin
                    if (upd.valid) begin
                        state <= bpu_types_pkg::upd_read;
                    end
                end
                bpu_types_pkg::upd_read: begin
                    state <= bpu_types_pkg::upd_write;
                end
                bpu_types_pkg::upd_write: begin
                    state   <= bpu_types_pkg::upd_idle;
                    history <= {history[INDEX_WIDTH-2:0], upd_entry.taken};
                end
                default: begin
                    state <= bpu_types_pkg::upd_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bpu_types_pkg::upd_idle && upd.valid) begin
            upd_entry <= upd.data;
        end
        if (state == bpu_types_pkg::upd_read) begin
            upd_counter_q <= upd_counter;
        end
    end

endmodule

`default_nettype wire

/* bpu/branch_target_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_target_buffer #(
    parameter int INDEX_WIDTH = 6,
    parameter int TAG_WIDTH   = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  stall,
    input  wire bpu_types_pkg::addr_t  lookup_pc,
    output logic                       hit,
    output bpu_types_pkg::addr_t       target,
    input  wire logic                  alloc_en,
    input  wire bpu_types_pkg::addr_t  alloc_pc,
    input  wire bpu_types_pkg::addr_t  alloc_target,
    input  wire logic                  inval_en,
    input  wire bpu_types_pkg::addr_t  inval_pc
);

    localparam int ENTRIES = 2 ** INDEX_WIDTH;
    localparam int TAG_LSB = INDEX_WIDTH + 2;
    localparam int TAG_MSB = INDEX_WIDTH + TAG_WIDTH + 1;

    logic                 valid_q  [ENTRIES];
    logic [TAG_WIDTH-1:0] tag_q    [ENTRIES];
    bpu_types_pkg::addr_t target_q [ENTRIES];

    logic [INDEX_WIDTH-1:0] lookup_index;
    logic [INDEX_WIDTH-1:0] alloc_index;
    logic [INDEX_WIDTH-1:0] inval_index;
    logic [TAG_WIDTH-1:0]   lookup_tag;
    logic [TAG_WIDTH-1:0]   alloc_tag;
    logic [TAG_WIDTH-1:0]   inval_tag;
    logic                   inval_match;

    assign lookup_index = lookup_pc[INDEX_WIDTH+1:2];
    assign alloc_index  = alloc_pc[INDEX_WIDTH+1:2];
    assign inval_index  = inval_pc[INDEX_WIDTH+1:2];
    assign lookup_tag   = lookup_pc[TAG_MSB:TAG_LSB];
    assign alloc_tag    = alloc_pc[TAG_MSB:TAG_LSB];
    assign inval_tag    = inval_pc[TAG_MSB:TAG_LSB];

    // a different branch sharing the slot must survive the invalidate.
    assign inval_match = inval_en && valid_q[inval_index] && (tag_q[inval_index] == inval_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            if (inval_match) begin
                valid_q[inval_index] <= 1'b0;
            end
            if (alloc_en) begin
                valid_q[alloc_index] <= 1'b1; // later assignment, so allocate wins a collision.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            tag_q[alloc_index]    <= alloc_tag;
            target_q[alloc_index] <= alloc_target;
        end
    end

    // registered lookup, held while fetch is stalled.
    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (!stall) begin
            hit <= valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            target <= target_q[lookup_index];
        end
    end

endmodule

`default_nettype wire

/* bpu/pattern_history_table.sv */
`timescale 1ns/1ns
`default_nettype none

module pattern_history_table #(
    parameter int INDEX_WIDTH = 6
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [INDEX_WIDTH-1:0]   lookup_index,
    output bpu_types_pkg::counter_e       lookup_state,
    input  wire logic [INDEX_WIDTH-1:0]   update_index,
    output bpu_types_pkg::counter_e       update_state,
    input  wire logic                     write_en,
    input  wire bpu_types_pkg::counter_e  write_state
);

    localparam int ENTRIES = 2 ** INDEX_WIDTH;

    bpu_types_pkg::counter_e table_q [ENTRIES];

    // every counter starts weakly not-taken so one taken outcome flips it.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                table_q[i] <= bpu_types_pkg::weak_not_taken;
            end
        end else if (write_en) begin
            table_q[update_index] <= write_state;
        end
    end

    // both reads see the table before this cycle's write.
    assign lookup_state = table_q[lookup_index];
    assign update_state = table_q[update_index];

endmodule

`default_nettype wire

/* common/bpu_cfg_pkg.sv */
`default_nettype none

package bpu_cfg_pkg;

    // history length and table index width are the same.
    localparam int INDEX_WIDTH_DEFAULT = 6;

    // tag bits taken from the pc right above the index.
    localparam int TAG_WIDTH_DEFAULT = 8;

    // resolve queue entries, equal to the credits the execute stage starts with.
    localparam int QUEUE_DEPTH_DEFAULT = 4;

endpackage

`default_nettype wire

/* common/bpu_types_pkg.sv */
`default_nettype none

package bpu_types_pkg;

    // instruction address; bits 1:0 are alignment and never used for indexing.
    typedef logic [31:0] addr_t;

    // 2-bit saturating counter, same encoding as the existing fetch unit.
    typedef enum logic [1:0] {
        weak_not_taken   = 2'b00,
        weak_taken       = 2'b01,
        strong_taken     = 2'b10,
        strong_not_taken = 2'b11
    } counter_e;

    // branch outcome as resolved in execute.
    typedef struct packed {
        addr_t pc;
        addr_t target;
        logic  taken;
    } resolved_t;

    // prediction payload; the valid bit travels on its own port.
    typedef struct packed {
        addr_t npc;
    } predict_t;

    // states of the predictor's read-modify-write update.
    typedef enum logic [1:0] {
        upd_idle,
        upd_read,
        upd_write
    } update_state_e;

endpackage

`default_nettype wire

/* common/resolve_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface resolve_if;

    logic                     valid;   // one-cycle handover of the head entry.
    bpu_types_pkg::resolved_t data;
    logic                     credit;  // one-cycle pulse, predictor is free again.

    modport queue_side (
        output valid,
        output data,
        input  credit
    );

    modport bpu_side (
        input  valid,
        input  data,
        output credit
    );

endinterface

`default_nettype wire

/* dv/bpu_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module bpu_assert #(
    parameter int QUEUE_DEPTH = 4
) (
    input wire logic                             clk,
    input wire logic                             rst,
    input wire logic [$clog2(QUEUE_DEPTH+1)-1:0] count,
    input wire logic                             pop,
    input wire logic                             in_credit
);

    logic credit_held; // a handover spends the credit and each returned pulse refills it.

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_held <= 1'b1;
        end else begin
            credit_held <= (credit_held || in_credit) && !pop;
        end
    end

    queue_bounded: assert property (@(posedge clk) disable iff (rst)
        int'(count) <= QUEUE_DEPTH)
        else $error("resolve queue holds more than %0d entries", QUEUE_DEPTH);

    // the predictor holds one entry, so a handover spends the only credit.
    handover_needs_credit: assert property (@(posedge clk) disable iff (rst)
        pop |-> credit_held || in_credit)
        else $error("entry handed to the predictor without a credit");

    single_handover: assert property (@(posedge clk) disable iff (rst)
        pop |=> !pop)
        else $error("two handovers in a row on one credit");

    credit_single_pulse: assert property (@(posedge clk) disable iff (rst)
        in_credit |=> !in_credit)
        else $error("upstream credit held high for two cycles");

endmodule

bind resolve_queue bpu_assert #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_bpu_assert (
    .clk       (clk),
    .rst       (rst),
    .count     (count),
    .pop       (pop),
    .in_credit (in_credit)
);

`default_nettype wire

/* dv/tb_bpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_bpu;

    localparam int IW          = bpu_cfg_pkg::INDEX_WIDTH_DEFAULT;
    localparam int TW          = bpu_cfg_pkg::TAG_WIDTH_DEFAULT;
    localparam int QUEUE_DEPTH = bpu_cfg_pkg::QUEUE_DEPTH_DEFAULT;
    localparam int ENTRIES     = 2 ** IW;
    localparam int TAG_LSB     = IW + 2;
    localparam int TAG_MSB     = IW + TW + 1;
    localparam int MAX_TRAIN   = 12;
    localparam int MAX_UPDATES = 60;
    localparam int MAX_LOOKUPS = 80;
    // roughly six cycles per drained update and two per lookup, then doubled.
    localparam int TIMEOUT_CYCLES = 2 * (MAX_UPDATES * 6 + MAX_LOOKUPS * 2 + 20);

    localparam bpu_types_pkg::addr_t BRANCH_PC     = 32'h0000_1040;
    localparam bpu_types_pkg::addr_t BRANCH_TARGET = 32'h0000_2000;

    logic                 clk;
    logic                 rst;
    logic                 stall;
    bpu_types_pkg::addr_t fetch_pc;
    logic                 predict_valid;
    bpu_types_pkg::addr_t predict_npc;
    logic                 inval_valid;
    bpu_types_pkg::addr_t inval_pc;
    logic                 resolve_valid;
    bpu_types_pkg::addr_t resolve_pc;
    bpu_types_pkg::addr_t resolve_target;
    logic                 resolve_taken;
    logic                 resolve_credit;

    logic [IW-1:0]           hist_m;
    bpu_types_pkg::counter_e pht_m [ENTRIES];
    logic                    btb_valid_m [ENTRIES];
    logic [TW-1:0]           btb_tag_m [ENTRIES];
    bpu_types_pkg::addr_t    btb_target_m [ENTRIES];

    int          sent_count = 0;
    int          credits_returned = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'd94;

    bpu_top #(
        .INDEX_WIDTH (IW),
        .TAG_WIDTH   (TW),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .fetch_pc       (fetch_pc),
        .predict_valid  (predict_valid),
        .predict_npc    (predict_npc),
        .inval_valid    (inval_valid),
        .inval_pc       (inval_pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target),
        .resolve_taken  (resolve_taken),
        .resolve_credit (resolve_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
        stop_with_failure();
    end

    // each credit pulse lasts one cycle, so one falling edge sees it once.
    always @(negedge clk) begin
        if (!rst && resolve_credit) begin
            credits_returned++;
        end
    end

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic check_valid(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s: expected %b, got %b", what, expected, actual));
        end
    endtask

    task automatic check_addr(input bpu_types_pkg::addr_t actual,
                              input bpu_types_pkg::addr_t expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s: expected %h, got %h", what, expected, actual));
        end
    endtask

    task automatic check_credits(input int actual, input int expected, input string what);
        if (actual != expected) begin
            report_mismatch($sformatf("%s: expected %0d, got %0d", what, expected, actual));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic bpu_types_pkg::addr_t rand_pc();
        return lcg_next() & 32'hFFFF_FFFC;
    endfunction

    // counters as a level from 0 (strongly not-taken) to 3 (strongly taken).
    function automatic int level_of(input bpu_types_pkg::counter_e c);
        case (c)
            bpu_types_pkg::strong_not_taken: return 0;
            bpu_types_pkg::weak_not_taken:   return 1;
            bpu_types_pkg::weak_taken:       return 2;
            default:                         return 3;
        endcase
    endfunction

    function automatic bpu_types_pkg::counter_e counter_of(input int lvl);
        case (lvl)
            0:       return bpu_types_pkg::strong_not_taken;
            1:       return bpu_types_pkg::weak_not_taken;
            2:       return bpu_types_pkg::weak_taken;
            default: return bpu_types_pkg::strong_taken;
        endcase
    endfunction

    function automatic logic model_taken(input bpu_types_pkg::addr_t pc);
        return level_of(pht_m[pc[IW+1:2] ^ hist_m]) >= 2;
    endfunction

    function automatic logic model_valid(input bpu_types_pkg::addr_t pc);
        logic [IW-1:0] slot;
        slot = pc[IW+1:2];
        return model_taken(pc) && btb_valid_m[slot] && (btb_tag_m[slot] == pc[TAG_MSB:TAG_LSB]);
    endfunction

    function automatic void model_update(input bpu_types_pkg::addr_t pc,
                                         input bpu_types_pkg::addr_t target, input logic taken);
        logic [IW-1:0] idx;
        logic [IW-1:0] slot;
        int            lvl;
        idx  = pc[IW+1:2] ^ hist_m;
        slot = pc[IW+1:2];
        lvl  = level_of(pht_m[idx]);
        if (taken) begin
            lvl = (lvl < 3) ? lvl + 1 : 3;
            btb_valid_m[slot]  = 1'b1;
            btb_tag_m[slot]    = pc[TAG_MSB:TAG_LSB];
            btb_target_m[slot] = target;
        end else begin
            lvl = (lvl > 0) ? lvl - 1 : 0;
        end
        pht_m[idx] = counter_of(lvl);
        hist_m     = {hist_m[IW-2:0], taken};
    endfunction

    function automatic void model_invalidate(input bpu_types_pkg::addr_t pc);
        logic [IW-1:0] slot;
        slot = pc[IW+1:2];
        if (btb_valid_m[slot] && btb_tag_m[slot] == pc[TAG_MSB:TAG_LSB]) begin
            btb_valid_m[slot] = 1'b0;
        end
    endfunction

    task automatic send_resolve(input bpu_types_pkg::addr_t pc,
                                input bpu_types_pkg::addr_t target, input logic taken);
        while (QUEUE_DEPTH - sent_count + credits_returned <= 0) begin
            @(negedge clk);
        end
        resolve_valid  = 1'b1;
        resolve_pc     = pc;
        resolve_target = target;
        resolve_taken  = taken;
        sent_count++;
        model_update(pc, target, taken); // the predictor drains in send order.
        @(negedge clk);
        resolve_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (credits_returned != sent_count) begin
            @(negedge clk);
        end
    endtask

    task automatic do_lookup(input bpu_types_pkg::addr_t pc);
        logic                 exp_valid;
        bpu_types_pkg::addr_t exp_npc;
        fetch_pc  = pc;
        stall     = 1'b0;
        exp_valid = model_valid(pc);
        exp_npc   = btb_target_m[pc[IW+1:2]];
        @(negedge clk);
        check_valid(predict_valid, exp_valid, $sformatf("predict_valid for pc %h", pc));
        if (exp_valid) begin
            check_addr(predict_npc, exp_npc, $sformatf("predict_npc for pc %h", pc));
        end
    endtask

    task automatic do_invalidate(input bpu_types_pkg::addr_t pc);
        inval_valid = 1'b1;
        inval_pc    = pc;
        @(negedge clk);
        inval_valid = 1'b0;
        model_invalidate(pc);
    endtask

    task automatic train_until_taken(input bpu_types_pkg::addr_t pc,
                                     input bpu_types_pkg::addr_t target);
        int n;
        n = 0;
        do begin
            if (n == MAX_TRAIN) begin
                $display("branch at %h still not taken after %0d taken resolutions", pc, n);
                stop_with_failure();
            end
            send_resolve(pc, target, 1'b1);
            wait_drained();
            do_lookup(pc); // the predictor must flip on the same resolution as the model.
            n++;
        end while (!model_taken(pc));
    endtask

    task automatic after_reset_test();
        repeat (8) begin
            do_lookup(rand_pc());
        end
        check_credits(credits_returned, 0, "credit pulses with nothing sent");
    endtask

    task automatic training_test();
        train_until_taken(BRANCH_PC, BRANCH_TARGET);
        check_valid(predict_valid, 1'b1, "trained branch predicted taken");
        check_addr(predict_npc, BRANCH_TARGET, "trained branch target");
    endtask

    task automatic untraining_test();
        repeat (10) begin
            send_resolve(BRANCH_PC, BRANCH_TARGET, 1'b0);
        end
        wait_drained();
        do_lookup(BRANCH_PC);
        check_valid(predict_valid, 1'b0, "untrained branch predicted not-taken");
        train_until_taken(BRANCH_PC, BRANCH_TARGET);
        check_valid(predict_valid, 1'b1, "retrained branch predicted taken");
    endtask

    task automatic invalidate_test();
        bpu_types_pkg::addr_t alias_pc;
        alias_pc = BRANCH_PC ^ (32'd1 << TAG_LSB); // same slot, other tag.
        do_invalidate(alias_pc);
        do_lookup(BRANCH_PC);
        check_valid(predict_valid, 1'b1, "entry kept after invalidate with another tag");
        do_invalidate(BRANCH_PC);
        do_lookup(BRANCH_PC);
        check_valid(predict_valid, 1'b0, "entry dropped after matching invalidate");
    endtask

    task automatic credit_test();
        bpu_types_pkg::addr_t pcs [QUEUE_DEPTH];
        logic [31:0]          r;
        int                   base;
        base = credits_returned;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            pcs[i] = rand_pc();
            r      = lcg_next();
            send_resolve(pcs[i], rand_pc(), r[27]);
        end
        wait_drained();
        repeat (8) @(negedge clk);
        check_credits(credits_returned - base, QUEUE_DEPTH, "credits after a full burst");
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            if (r[25]) begin
                do_lookup(pcs[int'(r[31:28]) % QUEUE_DEPTH]);
            end else begin
                do_lookup(rand_pc());
            end
        end
    endtask

    task automatic stall_test();
        train_until_taken(BRANCH_PC, BRANCH_TARGET);
        stall    = 1'b1;
        fetch_pc = rand_pc();
        repeat (4) begin
            @(negedge clk);
            check_valid(predict_valid, model_valid(BRANCH_PC), "predict_valid under stall");
            check_addr(predict_npc, BRANCH_TARGET, "predict_npc under stall");
            fetch_pc = rand_pc();
        end
        stall = 1'b0;
        do_lookup(rand_pc());
        do_lookup(BRANCH_PC);
    endtask

    initial begin
        rst            = 1'b1;
        stall          = 1'b0;
        fetch_pc       = '0;
        inval_valid    = 1'b0;
        inval_pc       = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_target = '0;
        resolve_taken  = 1'b0;
        hist_m         = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            pht_m[i]        = bpu_types_pkg::weak_not_taken;
            btb_valid_m[i]  = 1'b0;
            btb_tag_m[i]    = '0;
            btb_target_m[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        after_reset_test();
        training_test();
        untraining_test();
        invalidate_test();
        credit_test();
        stall_test();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
common/bpu_types_pkg.sv
common/bpu_cfg_pkg.sv
common/resolve_if.sv
bpu/pattern_history_table.sv
bpu/branch_target_buffer.sv
bpu/bpu.sv
logic/resolve_queue.sv
logic/bpu_top.sv
dv/bpu_assert.sv
dv/tb_bpu.sv

/* logic/bpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bpu_top #(
    parameter int INDEX_WIDTH = bpu_cfg_pkg::INDEX_WIDTH_DEFAULT,
    parameter int TAG_WIDTH   = bpu_cfg_pkg::TAG_WIDTH_DEFAULT,
    parameter int QUEUE_DEPTH = bpu_cfg_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  stall,
    input  wire bpu_types_pkg::addr_t  fetch_pc,
    output logic                       predict_valid,
    output bpu_types_pkg::addr_t       predict_npc,
    input  wire logic                  inval_valid,
    input  wire bpu_types_pkg::addr_t  inval_pc,
    input  wire logic                  resolve_valid,
    input  wire bpu_types_pkg::addr_t  resolve_pc,
    input  wire bpu_types_pkg::addr_t  resolve_target,
    input  wire logic                  resolve_taken,
    output logic                       resolve_credit
);

    bpu_types_pkg::resolved_t resolve_data;
    bpu_types_pkg::predict_t  predict;

    resolve_if rif ();

    assign resolve_data.pc     = resolve_pc;
    assign resolve_data.target = resolve_target;
    assign resolve_data.taken  = resolve_taken;
    assign predict_npc         = predict.npc;

    resolve_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_resolve_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (resolve_valid),
        .in_data   (resolve_data),
        .in_credit (resolve_credit),
        .out       (rif.queue_side)
    );

    bpu #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .TAG_WIDTH   (TAG_WIDTH)
    ) u_bpu (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .fetch_pc      (fetch_pc),
        .predict_valid (predict_valid),
        .predict       (predict),
        .inval_valid   (inval_valid),
        .inval_pc      (inval_pc),
        .upd           (rif.bpu_side)
    );

endmodule

`default_nettype wire

/* logic/resolve_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module resolve_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      in_valid,
    input  wire bpu_types_pkg::resolved_t  in_data,
    output logic                           in_credit,
    resolve_if.queue_side                  out
);

    localparam int PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    bpu_types_pkg::resolved_t mem [QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 ds_credit;   // predictor holds one entry at a time.
    logic                 pop;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pop       = ds_credit && (count != '0);
    assign out.valid = pop;
    assign out.data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            ds_credit <= 1'b1;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count     <= count + CNT_WIDTH'(in_valid) - CNT_WIDTH'(pop);
            ds_credit <= (ds_credit && !pop) || out.credit;
            // the slot of the handed-over entry counts as free once the predictor is done.
            in_credit <= out.credit;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_bpu -f flist.f -o tb_bpu > build.log 2>&1 &&
    ./obj_dir/tb_bpu > sim.log 2>&1 &&
    ! grep -qF '** FAIL **' sim.log &&
    echo "simulation passed" ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }
